// ==== Bender.yml ====
package:
  name: periph

sources:
  - design/periph_pkg.sv
  - design/periph_addr_decode.sv
  - design/gpio_regs.sv
  - design/read_data_reg.sv
  - design/periph_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/periph_tb.sv

// ==== compile.f ====
+incdir+test
design/periph_pkg.sv
design/periph_addr_decode.sv
design/gpio_regs.sv
design/read_data_reg.sv
design/periph_top.sv
test/periph_tb.sv

// ==== design/gpio_regs.sv ====
// ########################################
// GPIO register block
// Output register, input readback,
// audio select, per-pin function selects
// ########################################

`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t i_req,
    input  logic                    i_sel,
    input  periph_pkg::pins_t       i_ui_in,
    output periph_pkg::data_t       o_rdata,
    output periph_pkg::pins_t       o_uo_out,
    output logic                    o_audio_select
);

    logic [5:0]             ofs;       // Offset inside the 64-byte slot
    logic                   wr_en;
    periph_pkg::byte_t      wr_byte;
    periph_pkg::pins_t      gpio_out;
    periph_pkg::audio_sel_t audio_sel;
    periph_pkg::func_sel_t  func_sel [periph_pkg::PIN_W];

    // Offset of the select word for pin i
    function automatic logic [5:0] func_sel_ofs(input int pin);
        logic [5:0] step;
        step = 6'(pin * 4);
        return periph_pkg::FUNC_SEL_BASE + step;
    endfunction

    assign ofs     = i_req.addr[5:0];
    assign wr_en   = i_sel && (i_req.write_n != periph_pkg::SIZE_NONE);  // Any write size
    assign wr_byte = i_req.wdata[periph_pkg::BYTE_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (wr_en && ofs == periph_pkg::GPIO_OUT_OFS) begin
            gpio_out <= wr_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            audio_sel <= '0;
        end else if (wr_en && ofs == periph_pkg::AUDIO_SEL_OFS) begin
            audio_sel <= wr_byte[periph_pkg::AUDIO_SEL_W-1:0];
        end
    end

    // Pins 0 and 1 come up on the UART slot, the rest on GPIO
    for (genvar i = 0; i < periph_pkg::PIN_W; i++) begin : g_func_sel
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                if (i < 2) begin
                    func_sel[i] <= {1'b0, periph_pkg::UART_SLOT};
                end else begin
                    func_sel[i] <= {1'b0, periph_pkg::GPIO_SLOT};
                end
            end else if (wr_en && ofs == func_sel_ofs(i)) begin
                func_sel[i] <= wr_byte[periph_pkg::FUNC_SEL_W-1:0];
            end
        end

        // Bit 4 picks the byte region, where nothing drives pins
        assign o_uo_out[i] = (func_sel[i] == {1'b0, periph_pkg::GPIO_SLOT}) ? gpio_out[i]
                                                                           : 1'b0;
    end

    // Register readback, decoded on the offset alone.
    // The address decoder only passes it on when GPIO is selected.
    always_comb begin
        o_rdata = '0;
        case (ofs)
            periph_pkg::GPIO_OUT_OFS: begin
                o_rdata[periph_pkg::PIN_W-1:0] = gpio_out;
            end
            periph_pkg::GPIO_IN_OFS: begin
                o_rdata[periph_pkg::PIN_W-1:0] = i_ui_in;
            end
            periph_pkg::AUDIO_SEL_OFS: begin
                o_rdata[periph_pkg::AUDIO_SEL_W-1:0] = audio_sel;
            end
            default: begin
                for (int i = 0; i < periph_pkg::PIN_W; i++) begin
                    if (ofs == func_sel_ofs(i)) begin
                        o_rdata[periph_pkg::FUNC_SEL_W-1:0] = func_sel[i];
                    end
                end
            end
        endcase
    end

    assign o_audio_select = audio_sel[periph_pkg::AUDIO_SEL_W-1];  // Top bit routes audio out

endmodule

`default_nettype wire

// ==== design/periph_addr_decode.sv ====
// ########################################
// Address decode for the peripheral block
// Word/byte region split, GPIO select
// and the read response of the slot
// ########################################

`timescale 1ns/1ps
`default_nettype none

module periph_addr_decode (
    input  periph_pkg::periph_req_t i_req,
    input  periph_pkg::data_t       i_gpio_rdata,
    output logic                    o_gpio_sel,
    output periph_pkg::periph_rsp_t o_rsp
);

    // Address layout
    //   bit 10 set:   byte region, slot in bits 7:4, 16 bytes each
    //   bit 10 clear: word region, slot in bits 9:6, 64 bytes each
    logic                  region_byte;
    periph_pkg::slot_idx_t word_slot;

    assign region_byte = i_req.addr[periph_pkg::ADDR_W-1];
    assign word_slot   = i_req.addr[periph_pkg::ADDR_W-2 -: periph_pkg::SLOT_IDX_W];

    // Level select, high for the whole request cycle
    assign o_gpio_sel = !region_byte && (word_slot == periph_pkg::GPIO_SLOT);

    // Response of whichever slot the address falls in.
    // Only GPIO is fitted, so every other slot gives zero data.
    always_comb begin
        o_rsp = '0;
        if (region_byte) begin
            // Byte peripherals always answer in the same cycle
            o_rsp.ready = 1'b1;
        end else if (o_gpio_sel) begin
            o_rsp.rdata = i_gpio_rdata;
            o_rsp.ready = 1'b1;  // Readback is combinational
        end else begin
            // Empty word slot never acknowledges a read
            o_rsp.ready = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/periph_pkg.sv ====
// ########################################
// Peripheral block package
// Bus widths, address map, GPIO offsets
// Vector types and request/response structs
// ########################################

`default_nettype none

package periph_pkg;

    // Widths
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 11;
    localparam int BYTE_W      = 8;
    localparam int PIN_W       = 8;   // One PMOD worth of pins
    localparam int FUNC_SEL_W  = 5;   // Region bit plus slot index
    localparam int AUDIO_SEL_W = 3;
    localparam int SLOT_IDX_W  = 4;

    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [BYTE_W-1:0]      byte_t;
    typedef logic [PIN_W-1:0]       pins_t;
    typedef logic [FUNC_SEL_W-1:0]  func_sel_t;
    typedef logic [AUDIO_SEL_W-1:0] audio_sel_t;
    typedef logic [SLOT_IDX_W-1:0]  slot_idx_t;
    typedef logic [1:0]             xfer_size_t;

    // Transfer size code from the core
    // 00 byte, 01 half, 10 word, 11 idle
    localparam xfer_size_t SIZE_NONE = 2'b11;

    // Word slots in the 64-byte region
    localparam slot_idx_t GPIO_SLOT = 4'd1;
    localparam slot_idx_t UART_SLOT = 4'd2;   // Not fitted, reads as empty

    // Register offsets inside the GPIO slot
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] AUDIO_SEL_OFS = 6'h10;
    localparam logic [5:0] FUNC_SEL_BASE = 6'h20;  // One word per output pin

    // One request from the core, as seen in a single cycle
    typedef struct packed {
        addr_t      addr;
        data_t      wdata;     // Low 8, 16 or 32 bits valid
        xfer_size_t write_n;
        xfer_size_t read_n;
    } periph_req_t;

    // What the addressed slot answers
    typedef struct packed {
        data_t rdata;
        logic  ready;
    } periph_rsp_t;

endpackage

`default_nettype wire

// ==== design/periph_top.sv ====
// ########################################
// Peripheral block top level
// Packs core bus signals and connects
// decode, GPIO and read data register
// ########################################

`timescale 1ns/1ps
`default_nettype none

module periph_top (
    input  logic                   clk,
    input  logic                   rst_n,

    input  periph_pkg::pins_t      i_ui_in,         // Synchronized input PMOD
    input  periph_pkg::addr_t      i_addr,
    input  periph_pkg::data_t      i_data_in,
    input  periph_pkg::xfer_size_t i_data_write_n,
    input  periph_pkg::xfer_size_t i_data_read_n,
    input  logic                   i_data_read_complete,

    output periph_pkg::pins_t      o_uo_out,
    output logic                   o_audio_select,
    output periph_pkg::data_t      o_data_out,
    output logic                   o_data_ready
);

    periph_pkg::periph_req_t req;
    periph_pkg::periph_rsp_t rsp;
    periph_pkg::data_t       gpio_rdata;
    logic                    gpio_sel;

    // Core request in one bundle
    assign req.addr    = i_addr;
    assign req.wdata   = i_data_in;
    assign req.write_n = i_data_write_n;
    assign req.read_n  = i_data_read_n;

    periph_addr_decode periph_addr_decode_i (
        .i_req        (req),
        .i_gpio_rdata (gpio_rdata),
        .o_gpio_sel   (gpio_sel),
        .o_rsp        (rsp)
    );

    // Word slot 1
    gpio_regs gpio_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (req),
        .i_sel          (gpio_sel),
        .i_ui_in        (i_ui_in),
        .o_rdata        (gpio_rdata),
        .o_uo_out       (o_uo_out),
        .o_audio_select (o_audio_select)
    );

    read_data_reg read_data_reg_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (req),
        .i_rsp           (rsp),
        .i_read_complete (i_data_read_complete),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

endmodule

`default_nettype wire

// ==== design/read_data_reg.sv ====
// ########################################
// Read data register
// Captures and holds the read response
// and drives the data-ready strobe
// ########################################

`timescale 1ns/1ps
`default_nettype none

module read_data_reg (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::periph_req_t i_req,
    input  periph_pkg::periph_rsp_t i_rsp,
    input  logic                    i_read_complete,
    output periph_pkg::data_t       o_data_out,
    output logic                    o_data_ready
);

    logic              read_req;
    logic              write_req;
    logic              capture;
    logic              hold;      // Data register owns a value the core has not taken yet
    logic              ready_q;
    periph_pkg::data_t data_q;

    assign read_req  = i_req.read_n != periph_pkg::SIZE_NONE;
    assign write_req = i_req.write_n != periph_pkg::SIZE_NONE;

    // Take a new value only when nothing is held
    assign capture = read_req && i_rsp.ready && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (capture) begin
                hold <= 1'b1;
            end else if (i_read_complete) begin
                hold <= 1'b0;   // Released one cycle after the pulse
            end
            ready_q <= read_req && i_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rsp.rdata;
        end
    end

    assign o_data_out = data_q;

    // Writes complete in their own cycle, reads one cycle later
    assign o_data_ready = ready_q || write_req;

endmodule

`default_nettype wire

// ==== test/periph_ref.svh ====
// ########################################
// Reference model of the peripheral block
// GPIO register copy, expected readback
// and expected output pin drive
// ########################################

`ifndef PERIPH_REF_SVH
`define PERIPH_REF_SVH

// Copy of the GPIO registers, advanced by the comparing process
periph_pkg::pins_t      model_out;
periph_pkg::audio_sel_t model_audio;
periph_pkg::func_sel_t  model_sel [periph_pkg::PIN_W];

task automatic reset_model();
    model_out   = '0;
    model_audio = '0;
    for (int i = 0; i < periph_pkg::PIN_W; i++) begin
        // Pins 0 and 1 start on the empty UART slot
        model_sel[i] = (i < 2) ? {1'b0, periph_pkg::UART_SLOT} : {1'b0, periph_pkg::GPIO_SLOT};
    end
endtask

// Word region with slot index in bits 9:6
function automatic logic in_gpio_slot(input periph_pkg::addr_t a);
    return (a[10] == 1'b0) && (a[9:6] == periph_pkg::GPIO_SLOT);
endfunction

// Byte region and GPIO answer in the request cycle
function automatic logic answers_at_once(input periph_pkg::addr_t a);
    return a[10] || in_gpio_slot(a);
endfunction

function automatic periph_pkg::data_t expected_readback(input periph_pkg::addr_t a,
                                                        input periph_pkg::pins_t ui);
    periph_pkg::data_t v;
    logic [5:0]        ofs;
    v   = '0;
    ofs = a[5:0];
    if (in_gpio_slot(a)) begin
        if (ofs == periph_pkg::GPIO_OUT_OFS) begin
            v[7:0] = model_out;
        end else if (ofs == periph_pkg::GPIO_IN_OFS) begin
            v[7:0] = ui;
        end else if (ofs == periph_pkg::AUDIO_SEL_OFS) begin
            v[2:0] = model_audio;
        end
        for (int i = 0; i < periph_pkg::PIN_W; i++) begin
            if (ofs == periph_pkg::FUNC_SEL_BASE + 6'(4 * i)) begin
                v[4:0] = model_sel[i];
            end
        end
    end
    return v;  // Empty slots and the byte region read zero
endfunction

function automatic periph_pkg::pins_t pin_drive();
    periph_pkg::pins_t p;
    for (int i = 0; i < periph_pkg::PIN_W; i++) begin
        p[i] = (model_sel[i] == {1'b0, periph_pkg::GPIO_SLOT}) ? model_out[i] : 1'b0;
    end
    return p;
endfunction

task automatic apply_write(input periph_pkg::addr_t a, input periph_pkg::data_t wdata);
    logic [5:0] ofs;
    ofs = a[5:0];
    if (in_gpio_slot(a)) begin
        if (ofs == periph_pkg::GPIO_OUT_OFS) begin
            model_out = wdata[7:0];
        end else if (ofs == periph_pkg::AUDIO_SEL_OFS) begin
            model_audio = wdata[2:0];
        end
        for (int i = 0; i < periph_pkg::PIN_W; i++) begin
            if (ofs == periph_pkg::FUNC_SEL_BASE + 6'(4 * i)) begin
                model_sel[i] = wdata[4:0];
            end
        end
    end
endtask

`endif

// ==== test/periph_tb.sv ====
// ########################################
// Testbench for the peripheral block
// Clock, reset, bus stimulus, comparing
// process, watchdog and summary
// ########################################

`timescale 1ns/1ps
`default_nettype none

module periph_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int N_ITER      = 16;
    localparam int READ_WAIT   = 8;                  // Cycles a read may wait
    localparam int TEST_CYCLES = 10 + N_ITER * 120;  // Upper bound over all phases

    logic                   clk;
    logic                   rst_n;
    periph_pkg::pins_t      ui_in;
    periph_pkg::addr_t      addr;
    periph_pkg::data_t      data_in;
    periph_pkg::xfer_size_t write_n;
    periph_pkg::xfer_size_t read_n;
    logic                   read_complete;
    periph_pkg::pins_t      uo_out;
    logic                   audio_select;
    periph_pkg::data_t      data_out;
    logic                   data_ready;

    int error_count;
    int check_count;

    // Expected state of the read path
    logic              exp_pending;   // Ready read seen last cycle
    logic              exp_hold;
    logic              exp_captured;
    periph_pkg::data_t exp_data;

    `include "periph_ref.svh"

    periph_top periph_top_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .i_data_read_complete (read_complete),
        .o_uo_out             (uo_out),
        .o_audio_select       (audio_select),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input periph_pkg::data_t exp,
                                   input periph_pkg::data_t got);
        $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
        error_count++;
    endtask

    function automatic periph_pkg::addr_t gpio_addr(input logic [5:0] ofs);
        return {1'b0, periph_pkg::GPIO_SLOT, ofs};
    endfunction

    function automatic periph_pkg::addr_t byte_addr();
        periph_pkg::addr_t a;
        a     = periph_pkg::addr_t'($urandom);
        a[10] = 1'b1;
        return a;
    endfunction

    function automatic periph_pkg::addr_t empty_slot_addr();
        periph_pkg::slot_idx_t s;
        s = periph_pkg::GPIO_SLOT;
        while (s == periph_pkg::GPIO_SLOT) begin
            s = periph_pkg::slot_idx_t'($urandom);
        end
        return {1'b0, s, 6'($urandom)};
    endfunction

    task automatic bus_write(input periph_pkg::addr_t a, input periph_pkg::data_t d);
        @(posedge clk);
        addr    <= a;
        data_in <= d;
        write_n <= periph_pkg::xfer_size_t'($urandom_range(0, 2));  // Byte, half or word
        @(posedge clk);
        write_n <= periph_pkg::SIZE_NONE;
    endtask

    // Core holds the read until data_ready, then optionally completes it
    task automatic bus_read(input periph_pkg::addr_t a, input logic complete);
        int   waited;
        logic acked;
        @(posedge clk);
        addr   <= a;
        read_n <= 2'b10;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!data_ready && waited < READ_WAIT);
        acked = data_ready;
        if (answers_at_once(a) && !acked) begin
            $display("Read at address %h got no data_ready within %0d cycles", a, READ_WAIT);
            error_count++;
        end
        @(posedge clk);
        read_n <= periph_pkg::SIZE_NONE;
        if (complete && acked) begin
            read_complete <= 1'b1;
        end
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic pulse_read_complete();
        @(posedge clk);
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    // Checks outputs against the model, then advances the model by this cycle's request
    always @(negedge clk) begin : compare_outputs
        logic              rd;
        logic              wr;
        logic              exp_ready;
        periph_pkg::pins_t exp_pins;
        if (rst_n) begin
            rd        = read_n !== periph_pkg::SIZE_NONE;
            wr        = write_n !== periph_pkg::SIZE_NONE;
            exp_ready = exp_pending || wr;
            exp_pins  = pin_drive();
            check_count += 3;
            if (data_ready !== exp_ready) begin
                report_mismatch("o_data_ready", exp_ready, data_ready);
            end
            if (uo_out !== exp_pins) begin
                report_mismatch("o_uo_out", exp_pins, uo_out);
            end
            if (audio_select !== model_audio[periph_pkg::AUDIO_SEL_W-1]) begin
                report_mismatch("o_audio_select", model_audio[2], audio_select);
            end
            if (exp_captured) begin
                check_count++;
                if (data_out !== exp_data) begin
                    report_mismatch("o_data_out", exp_data, data_out);
                end
            end
            if (rd && answers_at_once(addr) && !exp_hold) begin
                exp_data     = expected_readback(addr, ui_in);
                exp_hold     = 1'b1;
                exp_captured = 1'b1;
            end else if (read_complete) begin
                exp_hold = 1'b0;  // Free again from the next cycle
            end
            exp_pending = rd && answers_at_once(addr);
            if (wr) begin
                apply_write(addr, data_in);
            end
        end
    end

    initial begin : watchdog
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("Checks failed");
        $finish;
    end

    initial begin : stimulus
        periph_pkg::data_t     d;
        periph_pkg::func_sel_t sel_val;
        void'($urandom(94960));
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        data_in       = '0;
        write_n       = periph_pkg::SIZE_NONE;
        read_n        = periph_pkg::SIZE_NONE;
        read_complete = 1'b0;
        error_count   = 0;
        check_count   = 0;
        exp_pending   = 1'b0;
        exp_hold      = 1'b0;
        exp_captured  = 1'b0;
        exp_data      = '0;
        reset_model();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Idle state right after reset
        @(negedge clk);
        check_count++;
        if (uo_out !== '0 || audio_select !== 1'b0 || data_ready !== 1'b0) begin
            $display("Outputs not idle after reset at %0t", $time);
            error_count++;
        end

        // Output register and input readback, selects still at reset
        repeat (N_ITER) begin
            bus_write(gpio_addr(periph_pkg::GPIO_OUT_OFS), $urandom);
            bus_read(gpio_addr(periph_pkg::GPIO_OUT_OFS), 1'b1);
            @(posedge clk);
            ui_in <= periph_pkg::pins_t'($urandom);
            bus_read(gpio_addr(periph_pkg::GPIO_IN_OFS), 1'b1);
        end

        // Function selects, about half of them on GPIO
        repeat (N_ITER / 2) begin
            for (int p = 0; p < periph_pkg::PIN_W; p++) begin
                if ($urandom_range(0, 1) == 1) begin
                    sel_val = {1'b0, periph_pkg::GPIO_SLOT};
                end else begin
                    sel_val = periph_pkg::func_sel_t'($urandom);
                end
                d      = $urandom;
                d[4:0] = sel_val;
                bus_write(gpio_addr(periph_pkg::FUNC_SEL_BASE + 6'(4 * p)), d);
            end
            bus_write(gpio_addr(periph_pkg::GPIO_OUT_OFS), $urandom);
            for (int p = 0; p < periph_pkg::PIN_W; p++) begin
                bus_read(gpio_addr(periph_pkg::FUNC_SEL_BASE + 6'(4 * p)), 1'b1);
            end
        end

        // Audio select
        repeat (N_ITER) begin
            bus_write(gpio_addr(periph_pkg::AUDIO_SEL_OFS), $urandom);
            bus_read(gpio_addr(periph_pkg::AUDIO_SEL_OFS), 1'b1);
        end

        // Ready timing per region, plus any GPIO offset
        repeat (N_ITER) begin
            bus_write(gpio_addr(periph_pkg::GPIO_OUT_OFS), $urandom);
            bus_read(byte_addr(), 1'b1);
            bus_read(empty_slot_addr(), 1'b0);
            bus_read(gpio_addr(6'($urandom)), 1'b1);
        end

        // Held data survives new requests until read_complete
        repeat (N_ITER / 2) begin
            @(posedge clk);
            ui_in <= periph_pkg::pins_t'($urandom);
            bus_read(gpio_addr(periph_pkg::GPIO_IN_OFS), 1'b0);
            @(posedge clk);
            ui_in <= periph_pkg::pins_t'($urandom);
            bus_read(gpio_addr(periph_pkg::GPIO_IN_OFS), 1'b0);
            bus_read(byte_addr(), 1'b0);
            pulse_read_complete();
            bus_read(gpio_addr(periph_pkg::GPIO_IN_OFS), 1'b1);
        end

        repeat (3) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
